//--- src/fpx_pkg.sv
package fpx_pkg;

    // ==============================
    // Format widths and types
    // ==============================

    localparam int EXP_W  = 15;
    localparam int MANT_W = 64;

    // Carry bit, 64 significand bits, then guard, round and sticky
    localparam int WORK_W = 68;

    typedef logic [EXP_W-1:0]  exp_t;
    typedef logic [MANT_W-1:0] mant_t;
    typedef logic [WORK_W-1:0] work_mant_t;

    // 80-bit extended format with an explicit integer bit
    typedef struct packed {
        logic        sign;
        exp_t        exp;
        logic        int_bit;
        logic [62:0] frac;
    } ext_float_t;

    // ==============================
    // Special encodings
    // ==============================

    localparam exp_t EXP_MAX = '1;

    // Canonical quiet NaN, positive, top fraction bit set
    localparam ext_float_t QNAN = '{
        sign:    1'b0,
        exp:     EXP_MAX,
        int_bit: 1'b1,
        frac:    {1'b1, 62'd0}
    };

    // ==============================
    // Enums
    // ==============================

    typedef enum logic [1:0] {
        RND_NEAREST = 2'd0,
        RND_DOWN    = 2'd1,
        RND_UP      = 2'd2,
        RND_ZERO    = 2'd3
    } round_mode_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CLASSIFY,
        ST_ALIGN,
        ST_ADD,
        ST_NORM,
        ST_ROUND
    } fsm_state_t;

endpackage

//--- src/fpx_classify.sv
`timescale 1ns/10ps

module fpx_classify import fpx_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       load,
    input  ext_float_t operand_a,
    input  ext_float_t operand_b,
    input  logic       subtract,
    output logic       sign_a,
    output logic       sign_b,
    output exp_t       exp_a,
    output exp_t       exp_b,
    output mant_t      mant_a,
    output mant_t      mant_b,
    output logic       zero_a,
    output logic       zero_b,
    output logic       inf_a,
    output logic       inf_b,
    output logic       nan_a,
    output logic       nan_b,
    output logic       cmp_equal,
    output logic       cmp_less,
    output logic       cmp_greater
);

    logic eff_sign_b;
    logic is_zero_a, is_zero_b;
    logic is_inf_a, is_inf_b;
    logic is_nan_a, is_nan_b;
    logic [EXP_W+MANT_W-1:0] mag_a, mag_b;
    logic eq_c, lt_c, gt_c;

    assign eff_sign_b = operand_b.sign ^ subtract;

    // Denormals count as zero
    assign is_zero_a = (operand_a.exp == '0);
    assign is_zero_b = (operand_b.exp == '0);

    assign is_inf_a = (operand_a.exp == EXP_MAX) && operand_a.int_bit && (operand_a.frac == '0);
    assign is_inf_b = (operand_b.exp == EXP_MAX) && operand_b.int_bit && (operand_b.frac == '0);
    assign is_nan_a = (operand_a.exp == EXP_MAX) && !is_inf_a;
    assign is_nan_b = (operand_b.exp == EXP_MAX) && !is_inf_b;

    // Magnitudes for ordering, a zero class compares as all zeros
    assign mag_a = is_zero_a ? '0 : {operand_a.exp, operand_a.int_bit, operand_a.frac};
    assign mag_b = is_zero_b ? '0 : {operand_b.exp, operand_b.int_bit, operand_b.frac};

    always_comb begin
        eq_c = 1'b0;
        lt_c = 1'b0;
        gt_c = 1'b0;
        if (is_nan_a || is_nan_b) begin
            // Unordered
        end else if (is_zero_a && is_zero_b) begin
            eq_c = 1'b1;
        end else if (operand_a.sign != eff_sign_b) begin
            lt_c = operand_a.sign;
            gt_c = !operand_a.sign;
        end else if (mag_a == mag_b) begin
            eq_c = 1'b1;
        end else begin
            // Larger magnitude is smaller when negative
            gt_c = (mag_a > mag_b) ^ operand_a.sign;
            lt_c = !gt_c;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sign_a      <= 1'b0;
            sign_b      <= 1'b0;
            exp_a       <= '0;
            exp_b       <= '0;
            mant_a      <= '0;
            mant_b      <= '0;
            zero_a      <= 1'b0;
            zero_b      <= 1'b0;
            inf_a       <= 1'b0;
            inf_b       <= 1'b0;
            nan_a       <= 1'b0;
            nan_b       <= 1'b0;
            cmp_equal   <= 1'b0;
            cmp_less    <= 1'b0;
            cmp_greater <= 1'b0;
        end else if (load) begin
            sign_a      <= operand_a.sign;
            sign_b      <= eff_sign_b;
            exp_a       <= operand_a.exp;
            exp_b       <= operand_b.exp;
            mant_a      <= {operand_a.int_bit, operand_a.frac};
            mant_b      <= {operand_b.int_bit, operand_b.frac};
            zero_a      <= is_zero_a;
            zero_b      <= is_zero_b;
            inf_a       <= is_inf_a;
            inf_b       <= is_inf_b;
            nan_a       <= is_nan_a;
            nan_b       <= is_nan_b;
            cmp_equal   <= eq_c;
            cmp_less    <= lt_c;
            cmp_greater <= gt_c;
        end
    end

endmodule

//--- src/fpx_align.sv
`timescale 1ns/10ps

module fpx_align import fpx_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       load,
    input  exp_t       exp_a,
    input  exp_t       exp_b,
    input  mant_t      mant_a,
    input  mant_t      mant_b,
    output work_mant_t aligned_a,
    output work_mant_t aligned_b,
    output exp_t       big_exp
);

    work_mant_t wa, wb;
    work_mant_t sa, sb;
    exp_t       diff;
    logic       a_big;

    // Right shift with the lost bits folded into sticky
    function automatic work_mant_t shr_sticky(input work_mant_t w, input exp_t d);
        work_mant_t r;
        work_mant_t lost_mask;
        if (d >= exp_t'(WORK_W)) begin
            r = work_mant_t'(|w);
        end else begin
            lost_mask = (work_mant_t'(1) << d) - work_mant_t'(1);
            r = w >> d;
            r[0] = r[0] | (|(w & lost_mask));
        end
        return r;
    endfunction

    assign wa    = {1'b0, mant_a, 3'b000};
    assign wb    = {1'b0, mant_b, 3'b000};
    assign a_big = (exp_a >= exp_b);
    assign diff  = a_big ? (exp_a - exp_b) : (exp_b - exp_a);
    assign sa    = a_big ? wa : shr_sticky(wa, diff);
    assign sb    = a_big ? shr_sticky(wb, diff) : wb;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            aligned_a <= '0;
            aligned_b <= '0;
            big_exp   <= '0;
        end else if (load) begin
            aligned_a <= sa;
            aligned_b <= sb;
            big_exp   <= a_big ? exp_a : exp_b;
        end
    end

endmodule

//--- src/fpx_add_norm.sv
`timescale 1ns/10ps

module fpx_add_norm import fpx_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       load_add,
    input  logic       load_norm,
    input  logic       sign_a,
    input  logic       sign_b,
    input  work_mant_t aligned_a,
    input  work_mant_t aligned_b,
    input  exp_t       big_exp,
    output logic       sum_sign,
    output work_mant_t norm_mant,
    output exp_t       norm_exp,
    output logic       zero_result,
    output logic       carry_overflow,
    output logic       norm_underflow
);

    work_mant_t raw_sum;
    logic       raw_sign;
    logic [6:0] lead_shift;

    // ==============================
    // Add stage
    // ==============================

    // Unlike signs subtract the smaller magnitude from the larger
    always_comb begin
        if (sign_a == sign_b) begin
            raw_sum  = aligned_a + aligned_b;
            raw_sign = sign_a;
        end else if (aligned_a >= aligned_b) begin
            raw_sum  = aligned_a - aligned_b;
            raw_sign = sign_a;
        end else begin
            raw_sum  = aligned_b - aligned_a;
            raw_sign = sign_b;
        end
    end

    // Status of the sum being loaded, so the FSM can exit in ST_ADD
    assign zero_result    = (raw_sum == '0);
    assign carry_overflow = raw_sum[WORK_W-1] && (big_exp == exp_t'(EXP_MAX - 1));

    // ==============================
    // Normalize stage
    // ==============================

    // Distance from the leading one to the integer bit position
    always_comb begin
        lead_shift = '0;
        for (int i = 0; i < WORK_W - 1; i++) begin
            if (norm_mant[i]) begin
                lead_shift = 7'(WORK_W - 2 - i);
            end
        end
    end

    assign norm_underflow = (norm_exp <= exp_t'(lead_shift));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sum_sign  <= 1'b0;
            norm_mant <= '0;
            norm_exp  <= '0;
        end else if (load_add) begin
            sum_sign <= raw_sign;
            if (raw_sum[WORK_W-1]) begin
                // Carry out, shift right and fold the lost bit into sticky
                norm_mant <= {1'b0, raw_sum[WORK_W-1:2], |raw_sum[1:0]};
                norm_exp  <= big_exp + 15'd1;
            end else begin
                norm_mant <= raw_sum;
                norm_exp  <= big_exp;
            end
        end else if (load_norm) begin
            norm_mant <= norm_mant << lead_shift;
            norm_exp  <= norm_exp - exp_t'(lead_shift);
        end
    end

endmodule

//--- src/fpx_round_pack.sv
`timescale 1ns/10ps

module fpx_round_pack import fpx_pkg::*; (
    input  work_mant_t  norm_mant,
    input  exp_t        norm_exp,
    input  logic        sum_sign,
    input  round_mode_t rounding_mode,
    output ext_float_t  packed_result,
    output logic        round_overflow,
    output logic        inexact
);

    logic        lsb;
    logic        guard_bit;
    logic        round_bit;
    logic        sticky_bit;
    logic        lost;
    logic        incr;
    logic [64:0] rounded;
    mant_t       rnd_mant;
    exp_t        rnd_exp;

    // Significand sits in bits 66:3 after normalization
    assign lsb        = norm_mant[3];
    assign guard_bit  = norm_mant[2];
    assign round_bit  = norm_mant[1];
    assign sticky_bit = norm_mant[0];
    assign lost       = guard_bit | round_bit | sticky_bit;

    always_comb begin
        case (rounding_mode)
            RND_NEAREST: incr = guard_bit & (round_bit | sticky_bit | lsb);
            RND_DOWN:    incr = sum_sign & lost;
            RND_UP:      incr = !sum_sign & lost;
            default:     incr = 1'b0;
        endcase
    end

    assign rounded = {1'b0, norm_mant[WORK_W-2:3]} + 65'(incr);

    // A carry out of the increment leaves 1.000..., shift it back down
    always_comb begin
        if (rounded[64]) begin
            rnd_mant = rounded[64:1];
            rnd_exp  = norm_exp + 15'd1;
        end else begin
            rnd_mant = rounded[63:0];
            rnd_exp  = norm_exp;
        end
    end

    assign round_overflow = (rnd_exp == EXP_MAX);
    assign inexact        = lost;

    always_comb begin
        if (round_overflow) begin
            packed_result = {sum_sign, EXP_MAX, 1'b1, 63'd0};
        end else begin
            packed_result = {sum_sign, rnd_exp, rnd_mant};
        end
    end

endmodule

//--- src/fpx_addsub.sv
`timescale 1ns/10ps

module fpx_addsub import fpx_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        enable,
    input  ext_float_t  operand_a,
    input  ext_float_t  operand_b,
    input  logic        subtract,
    input  round_mode_t rounding_mode,
    output ext_float_t  result,
    output logic        done,
    output logic        cmp_equal,
    output logic        cmp_less,
    output logic        cmp_greater,
    output logic        flag_invalid,
    output logic        flag_overflow,
    output logic        flag_underflow,
    output logic        flag_inexact
);

    fsm_state_t  state;

    // Operands held for the whole operation
    ext_float_t  op_a_q;
    ext_float_t  op_b_q;
    logic        sub_q;
    round_mode_t rmode_q;

    logic        sign_a, sign_b;
    exp_t        exp_a, exp_b;
    mant_t       mant_a, mant_b;
    logic        zero_a, zero_b, inf_a, inf_b, nan_a, nan_b;
    work_mant_t  aligned_a, aligned_b;
    exp_t        big_exp;
    logic        sum_sign;
    work_mant_t  norm_mant;
    exp_t        norm_exp;
    logic        zero_result, carry_overflow, norm_underflow;
    ext_float_t  packed_result;
    logic        round_overflow, inexact;
    logic        zero_sign;

    // Sign of an exact zero from unlike-signed operands
    assign zero_sign = (rmode_q == RND_DOWN);

    // ==============================
    // Datapath stages
    // ==============================

    fpx_classify i_fpx_classify (
        .clk         (clk),
        .reset       (reset),
        .load        (state == ST_CLASSIFY),
        .operand_a   (op_a_q),
        .operand_b   (op_b_q),
        .subtract    (sub_q),
        .sign_a      (sign_a),
        .sign_b      (sign_b),
        .exp_a       (exp_a),
        .exp_b       (exp_b),
        .mant_a      (mant_a),
        .mant_b      (mant_b),
        .zero_a      (zero_a),
        .zero_b      (zero_b),
        .inf_a       (inf_a),
        .inf_b       (inf_b),
        .nan_a       (nan_a),
        .nan_b       (nan_b),
        .cmp_equal   (cmp_equal),
        .cmp_less    (cmp_less),
        .cmp_greater (cmp_greater)
    );

    fpx_align i_fpx_align (
        .clk       (clk),
        .reset     (reset),
        .load      (state == ST_ALIGN),
        .exp_a     (exp_a),
        .exp_b     (exp_b),
        .mant_a    (mant_a),
        .mant_b    (mant_b),
        .aligned_a (aligned_a),
        .aligned_b (aligned_b),
        .big_exp   (big_exp)
    );

    fpx_add_norm i_fpx_add_norm (
        .clk            (clk),
        .reset          (reset),
        .load_add       (state == ST_ADD),
        .load_norm      (state == ST_NORM),
        .sign_a         (sign_a),
        .sign_b         (sign_b),
        .aligned_a      (aligned_a),
        .aligned_b      (aligned_b),
        .big_exp        (big_exp),
        .sum_sign       (sum_sign),
        .norm_mant      (norm_mant),
        .norm_exp       (norm_exp),
        .zero_result    (zero_result),
        .carry_overflow (carry_overflow),
        .norm_underflow (norm_underflow)
    );

    fpx_round_pack i_fpx_round_pack (
        .norm_mant      (norm_mant),
        .norm_exp       (norm_exp),
        .sum_sign       (sum_sign),
        .rounding_mode  (rmode_q),
        .packed_result  (packed_result),
        .round_overflow (round_overflow),
        .inexact        (inexact)
    );

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && enable) begin
            op_a_q  <= operand_a;
            op_b_q  <= operand_b;
            sub_q   <= subtract;
            rmode_q <= rounding_mode;
        end
    end

    // ==============================
    // Control FSM
    // ==============================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= ST_IDLE;
            result         <= '0;
            done           <= 1'b0;
            flag_invalid   <= 1'b0;
            flag_overflow  <= 1'b0;
            flag_underflow <= 1'b0;
            flag_inexact   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (enable) begin
                        flag_invalid   <= 1'b0;
                        flag_overflow  <= 1'b0;
                        flag_underflow <= 1'b0;
                        flag_inexact   <= 1'b0;
                        state          <= ST_CLASSIFY;
                    end
                end

                ST_CLASSIFY: begin
                    state <= ST_ALIGN;
                end

                ST_ALIGN: begin
                    // Special values finish here, otherwise alignment loads
                    done  <= 1'b1;
                    state <= ST_IDLE;
                    if (nan_a || nan_b || (inf_a && inf_b && (sign_a != sign_b))) begin
                        result       <= QNAN;
                        flag_invalid <= 1'b1;
                    end else if (inf_a) begin
                        result <= {sign_a, EXP_MAX, 1'b1, 63'd0};
                    end else if (inf_b) begin
                        result <= {sign_b, EXP_MAX, 1'b1, 63'd0};
                    end else if (zero_a && zero_b) begin
                        result <= {(sign_a == sign_b) ? sign_a : zero_sign, 79'd0};
                    end else if (zero_a) begin
                        result <= {sign_b, exp_b, mant_b};
                    end else if (zero_b) begin
                        result <= {sign_a, exp_a, mant_a};
                    end else begin
                        done  <= 1'b0;
                        state <= ST_ADD;
                    end
                end

                ST_ADD: begin
                    if (zero_result) begin
                        result <= {zero_sign, 79'd0};
                        done   <= 1'b1;
                        state  <= ST_IDLE;
                    end else if (carry_overflow) begin
                        // Carry only occurs for like signs
                        result        <= {sign_a, EXP_MAX, 1'b1, 63'd0};
                        flag_overflow <= 1'b1;
                        done          <= 1'b1;
                        state         <= ST_IDLE;
                    end else begin
                        state <= ST_NORM;
                    end
                end

                ST_NORM: begin
                    if (norm_underflow) begin
                        result         <= {sum_sign, 79'd0};
                        flag_underflow <= 1'b1;
                        done           <= 1'b1;
                        state          <= ST_IDLE;
                    end else begin
                        state <= ST_ROUND;
                    end
                end

                ST_ROUND: begin
                    result        <= packed_result;
                    flag_overflow <= round_overflow;
                    flag_inexact  <= inexact;
                    done          <= 1'b1;
                    state         <= ST_IDLE;
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- sim/fpx_clock_gen.sv
`timescale 1ns/10ps

module fpx_clock_gen (
    output logic clk,
    output logic reset
);

    localparam real HALF_PERIOD  = 2.0;
    localparam int  RESET_CYCLES = 2;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset held over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- sim/fpx_addsub_checker.sv
`timescale 1ns/10ps

module fpx_addsub_checker import fpx_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       done,
    input logic       cmp_equal,
    input logic       cmp_less,
    input logic       cmp_greater,
    input logic       flag_invalid,
    input logic       flag_overflow,
    input logic       flag_underflow,
    input ext_float_t result
);

    int unsigned fail_count = 0;

    // done is a single-cycle pulse
    a_done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            $error("done stayed high for two cycles");
            fail_count++;
        end

    a_cmp_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({cmp_equal, cmp_less, cmp_greater}))
        else begin
            $error("more than one comparison output is high");
            fail_count++;
        end

    // Invalid operations always deliver the canonical quiet NaN
    a_invalid_qnan: assert property (@(posedge clk) disable iff (reset)
        (done && flag_invalid) |-> (result == QNAN))
        else begin
            $error("flag_invalid with done but result is not QNAN");
            fail_count++;
        end

    a_ovf_udf: assert property (@(posedge clk) disable iff (reset)
        !(flag_overflow && flag_underflow))
        else begin
            $error("flag_overflow and flag_underflow both high");
            fail_count++;
        end

endmodule

bind fpx_addsub fpx_addsub_checker i_checker (
    .clk            (clk),
    .reset          (reset),
    .done           (done),
    .cmp_equal      (cmp_equal),
    .cmp_less       (cmp_less),
    .cmp_greater    (cmp_greater),
    .flag_invalid   (flag_invalid),
    .flag_overflow  (flag_overflow),
    .flag_underflow (flag_underflow),
    .result         (result)
);

//--- sim/tb_fpx_addsub.sv
`timescale 1ns/10ps

module tb_fpx_addsub import fpx_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 20;
    localparam int QUIET_CYCLES   = 10;
    localparam int MAX_TESTS      = 200;

    logic        clk;
    logic        reset;
    logic        enable;
    ext_float_t  operand_a;
    ext_float_t  operand_b;
    logic        subtract;
    round_mode_t rounding_mode;
    ext_float_t  result;
    logic        done;
    logic        cmp_equal;
    logic        cmp_less;
    logic        cmp_greater;
    logic        flag_invalid;
    logic        flag_overflow;
    logic        flag_underflow;
    logic        flag_inexact;

    // Test table loaded from sim/fpx_tests.txt
    string       test_name[$];
    ext_float_t  test_a[$];
    ext_float_t  test_b[$];
    logic        test_sub[$];
    round_mode_t test_rmode[$];
    ext_float_t  test_result[$];
    logic [2:0]  test_cmp[$];
    logic [3:0]  test_flags[$];

    logic [31:0] lcg_state;

    fpx_clock_gen i_fpx_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    fpx_addsub i_fpx_addsub (
        .clk            (clk),
        .reset          (reset),
        .enable         (enable),
        .operand_a      (operand_a),
        .operand_b      (operand_b),
        .subtract       (subtract),
        .rounding_mode  (rounding_mode),
        .result         (result),
        .done           (done),
        .cmp_equal      (cmp_equal),
        .cmp_less       (cmp_less),
        .cmp_greater    (cmp_greater),
        .flag_invalid   (flag_invalid),
        .flag_overflow  (flag_overflow),
        .flag_underflow (flag_underflow),
        .flag_inexact   (flag_inexact)
    );

    // ==============================
    // Helpers
    // ==============================

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_result(input string name, input round_mode_t rmode,
                                input ext_float_t expected, input ext_float_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[FAIL] %s mode %0d result: expected %h, actual %h",
                name, rmode, 80'(expected), 80'(actual)));
        end
    endtask

    // Order is equal, less, greater
    task automatic check_compare(input string name, input logic [2:0] expected,
                                 input logic [2:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[FAIL] %s compare: expected %b, actual %b",
                name, expected, actual));
        end
    endtask

    // Order is invalid, overflow, underflow, inexact
    task automatic check_flags(input string name, input logic [3:0] expected,
                               input logic [3:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[FAIL] %s flags: expected %b, actual %b",
                name, expected, actual));
        end
    endtask

    task automatic check_assertions(input string name);
        if (i_fpx_addsub.i_checker.fail_count != 0) begin
            stop_with_failure($sformatf("A checker assertion failed during test %s", name));
        end
    endtask

    task automatic read_tests();
        int               fd;
        int               code;
        string            word;
        logic [8*160-1:0] skip_line;
        logic [79:0]      a_v;
        logic [79:0]      b_v;
        logic [79:0]      res_v;
        logic [3:0]       sub_v;
        logic [3:0]       rm_v;
        logic [2:0]       cmp_v;
        logic [3:0]       flags_v;
        fd = $fopen("sim/fpx_tests.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open the test file sim/fpx_tests.txt");
        end
        while (test_name.size() < MAX_TESTS) begin
            code = $fscanf(fd, "%s", word);
            if (code != 1) begin
                break;
            end
            if (word.substr(0, 0) == "#") begin
                code = $fgets(skip_line, fd);
                continue;
            end
            code = $fscanf(fd, "%h %h %h %h %h %b %b",
                           a_v, b_v, sub_v, rm_v, res_v, cmp_v, flags_v);
            if (code != 7) begin
                stop_with_failure($sformatf("The line of test %s is malformed", word));
            end
            test_name.push_back(word);
            test_a.push_back(a_v);
            test_b.push_back(b_v);
            test_sub.push_back(sub_v[0]);
            test_rmode.push_back(round_mode_t'(rm_v[1:0]));
            test_result.push_back(res_v);
            test_cmp.push_back(cmp_v);
            test_flags.push_back(flags_v);
        end
        $fclose(fd);
        if (test_name.size() == 0) begin
            stop_with_failure("The test file holds no tests");
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_with_failure("Reset was never released");
            end
        end while (reset !== 1'b0);
    endtask

    // ==============================
    // One operation
    // ==============================

    task automatic run_test(input int idx, input logic busy_pulse);
        int    cycles;
        string name;
        name = test_name[idx];
        @(posedge clk);
        enable        <= 1'b1;
        operand_a     <= test_a[idx];
        operand_b     <= test_b[idx];
        subtract      <= test_sub[idx];
        rounding_mode <= test_rmode[idx];
        // Scrambled inputs so the DUT must work from its captured copy
        lcg_state = lcg_next(lcg_state);
        @(posedge clk);
        enable        <= 1'b0;
        operand_a     <= {lcg_state[15:0], lcg_state, lcg_state};
        operand_b     <= {lcg_state[31:16], lcg_state, ~lcg_state};
        subtract      <= lcg_state[7];
        rounding_mode <= round_mode_t'(lcg_state[3:2]);
        if (busy_pulse) begin
            // Enable seen by the DUT in ST_ALIGN and ignored there
            @(posedge clk);
            enable <= 1'b1;
            @(posedge clk);
            enable <= 1'b0;
        end
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_with_failure($sformatf("Test %s: done never arrived", name));
            end
        end while (!done);
        check_result(name, test_rmode[idx], test_result[idx], result);
        check_compare(name, test_cmp[idx], {cmp_equal, cmp_less, cmp_greater});
        check_flags(name, test_flags[idx],
                    {flag_invalid, flag_overflow, flag_underflow, flag_inexact});
        check_assertions(name);
        if (busy_pulse) begin
            for (int i = 0; i < QUIET_CYCLES; i++) begin
                @(negedge clk);
                if (done) begin
                    stop_with_failure($sformatf("Test %s: extra done after a busy enable",
                                                name));
                end
            end
            check_result(name, test_rmode[idx], test_result[idx], result);
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        enable        = 1'b0;
        operand_a     = '0;
        operand_b     = '0;
        subtract      = 1'b0;
        rounding_mode = RND_NEAREST;
        lcg_state     = 32'd68;
        read_tests();
        wait_reset_release();
        // Back-to-back runs where each test clears the flags of the last
        foreach (test_name[i]) begin
            run_test(i, 1'b0);
        end
        foreach (test_name[i]) begin
            run_test(i, 1'b1);
        end
        repeat (2) @(negedge clk);
        if (i_fpx_addsub.i_checker.fail_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_with_failure("A checker assertion failed at the end of the run");
        end
    end

endmodule

//--- sim/fpx_tests.txt
# name  operand_a  operand_b  subtract  rounding_mode  result  eq_lt_gt  inv_ovf_unf_inx
# operands and result are 80-bit hex, rounding mode 0 nearest, 1 down, 2 up, 3 zero
add_one_one       3FFF8000000000000000 3FFF8000000000000000 0 0 40008000000000000000 100 0000
add_one_two       3FFF8000000000000000 40008000000000000000 0 0 4000C000000000000000 010 0000
add_two_one       40008000000000000000 3FFF8000000000000000 0 0 4000C000000000000000 001 0000
sub_three_one     4000C000000000000000 3FFF8000000000000000 1 0 40008000000000000000 001 0000
sub_one_three     3FFF8000000000000000 4000C000000000000000 1 0 C0008000000000000000 001 0000
add_mixed_sign    BFFFC000000000000000 3FFE8000000000000000 0 0 BFFF8000000000000000 010 0000
add_neg_exp       C0008000000000000000 BFFF8000000000000000 0 0 C000C000000000000000 010 0000
sub_norm_shift    3FFFC000000000000000 3FFF8000000000000000 1 0 3FFE8000000000000000 001 0000
sub_flip_equal    3FFF8000000000000000 BFFF8000000000000000 1 0 40008000000000000000 100 0000
rnd_nearest       3FFF8000000000000000 3FBFC000000000000000 0 0 3FFF8000000000000001 001 0001
rnd_down          3FFF8000000000000000 3FBFC000000000000000 0 1 3FFF8000000000000000 001 0001
rnd_up            3FFF8000000000000000 3FBFC000000000000000 0 2 3FFF8000000000000001 001 0001
rnd_zero          3FFF8000000000000000 3FBFC000000000000000 0 3 3FFF8000000000000000 001 0001
rnd_neg_down      BFFF8000000000000000 BFBFC000000000000000 0 1 BFFF8000000000000001 010 0001
rnd_neg_up        BFFF8000000000000000 BFBFC000000000000000 0 2 BFFF8000000000000000 010 0001
rnd_tie_even      3FFF8000000000000000 3FBF8000000000000000 0 0 3FFF8000000000000000 001 0001
rnd_tie_odd       3FFF8000000000000001 3FBF8000000000000000 0 0 3FFF8000000000000002 001 0001
nan_a             7FFFC000000000000000 3FFF8000000000000000 0 0 7FFFC000000000000000 000 1000
nan_b             3FFF8000000000000000 FFFF8000000000000001 0 0 7FFFC000000000000000 000 1000
inf_minus_inf     7FFF8000000000000000 7FFF8000000000000000 1 0 7FFFC000000000000000 001 1000
inf_plus_inf      7FFF8000000000000000 7FFF8000000000000000 0 0 7FFF8000000000000000 100 0000
ninf_plus_one     FFFF8000000000000000 3FFF8000000000000000 0 0 FFFF8000000000000000 010 0000
one_plus_inf      3FFF8000000000000000 7FFF8000000000000000 0 0 7FFF8000000000000000 010 0000
x_minus_x         3FFFC000000000000000 3FFFC000000000000000 1 0 00000000000000000000 001 0000
x_minus_x_down    3FFFC000000000000000 3FFFC000000000000000 1 1 80000000000000000000 001 0000
zero_plus_x       00000000000000000000 4000C000000000000000 0 0 4000C000000000000000 010 0000
x_plus_nzero      C0008000000000000000 80000000000000000000 0 0 C0008000000000000000 010 0000
pzero_nzero       00000000000000000000 80000000000000000000 0 0 00000000000000000000 100 0000
pzero_nzero_down  00000000000000000000 80000000000000000000 0 1 80000000000000000000 100 0000
nzero_nzero       80000000000000000000 80000000000000000000 0 0 80000000000000000000 100 0000
denorm_plus_one   00004000000000000000 3FFF8000000000000000 0 0 3FFF8000000000000000 010 0000
two_plus_ndenorm  40008000000000000000 80000000000000000001 0 0 40008000000000000000 001 0000
overflow_pos      7FFEFFFFFFFFFFFFFFFF 7FFEFFFFFFFFFFFFFFFF 0 0 7FFF8000000000000000 100 0100
overflow_neg      FFFEFFFFFFFFFFFFFFFF FFFEFFFFFFFFFFFFFFFF 0 0 FFFF8000000000000000 100 0100
underflow_pos     00018000000000000001 00018000000000000000 1 0 00000000000000000000 001 0010
underflow_neg     80018000000000000001 80018000000000000000 1 0 80000000000000000000 010 0010
clear_after_flags 3FFF8000000000000000 3FFF8000000000000000 0 0 40008000000000000000 100 0000

//--- files.f
src/fpx_pkg.sv
src/fpx_classify.sv
src/fpx_align.sv
src/fpx_add_norm.sv
src/fpx_round_pack.sv
src/fpx_addsub.sv
sim/fpx_clock_gen.sv
sim/fpx_addsub_checker.sv
sim/tb_fpx_addsub.sv
